//--- design/stream_pkg.sv
`default_nettype none

package stream_pkg;

   // mesh coordinates of a node.
   localparam int X_W = 2;
   localparam int Y_W = 2;

   // request fields.
   localparam int OP_W   = 2;
   localparam int ADDR_W = 12;
   localparam int DATA_W = 32;
   localparam int MASK_W = 4;

   // request table.
   localparam int    ROM_WORDS  = 16;
   localparam int    ROM_ADDR_W = 4;
   localparam string ROM_FILE   = "design/packet_rom.hex";

   // outgoing flow control.
   localparam int MAX_CREDITS = 4;
   localparam int CREDIT_W    = 3;

   // the freeze register sits at one local word address.
   localparam logic [ADDR_W-1:0] FREEZE_ADDR = 12'h0f0;
   localparam logic              FREEZE_INIT = 1'b1;

   // a rom word is op, mask, addr, data, dest x, dest y from the top down.
   localparam int ROM_W = OP_W + MASK_W + ADDR_W + DATA_W + X_W + Y_W;

   // a link packet is the rom word with src x and src y below it.
   localparam int PKT_W = ROM_W + X_W + Y_W;

   // field positions inside a link packet.
   localparam int PKT_DATA_LSB = 2 * (X_W + Y_W);
   localparam int PKT_ADDR_LSB = PKT_DATA_LSB + DATA_W;
   localparam int PKT_OP_LSB   = PKT_ADDR_LSB + ADDR_W + MASK_W;

   typedef enum logic [OP_W-1:0] {
      OP_NOP   = 2'b00,
      OP_LOAD  = 2'b01,
      OP_STORE = 2'b10
   } op_e;

   typedef enum logic [0:0] {
      SS_SEND = 1'b0,
      SS_DONE = 1'b1
   } streamer_state_e;

endpackage

`default_nettype wire

//--- design/packet_rom.sv
`default_nettype none

module packet_rom import stream_pkg::*;
(
   input  wire logic [ROM_ADDR_W-1:0] rom_addr_i,
   output logic      [ROM_W-1:0]      rom_data_o
);

   // one request word per entry, filled in at elaboration.
   logic [ROM_W-1:0] rom_mem [ROM_WORDS];

   initial
   begin
      $readmemh(ROM_FILE, rom_mem);
   end

   // read has no register, the word is valid in the same cycle as the address.
   assign rom_data_o = rom_mem[rom_addr_i];

endmodule

`default_nettype wire

//--- design/packet_streamer.sv
`default_nettype none

module packet_streamer import stream_pkg::*;
(
   input  wire logic                  clk_i,
   input  wire logic                  rst_n_i,

   input  wire logic                  freeze_i,

   output logic      [ROM_ADDR_W-1:0] rom_addr_o,
   input  wire logic [ROM_W-1:0]      rom_data_i,

   output logic                       out_v_o,
   output logic      [ROM_W-1:0]      out_word_o,
   input  wire logic                  out_ready_i,

   output logic                       done_o
);

   localparam logic [ROM_ADDR_W-1:0] LAST_ADDR = ROM_ADDR_W'(ROM_WORDS - 1);

   streamer_state_e      state_r;
   logic [ROM_ADDR_W-1:0] addr_r;
   logic                  xfer;

   // the word is offered as long as the node is running and the table is not spent.
   assign out_v_o    = (state_r == SS_SEND) && !freeze_i;
   assign out_word_o = rom_data_i;
   assign rom_addr_o = addr_r;
   assign xfer       = out_v_o && out_ready_i;
   assign done_o     = (state_r == SS_DONE);

   always_ff @(posedge clk_i)
   begin
      if (!rst_n_i)
      begin
         state_r <= SS_SEND;
         addr_r  <= '0;
      end
      else
      begin
         case (state_r)
            SS_SEND:
            begin
               if (xfer)
               begin
                  if (addr_r == LAST_ADDR)
                  begin
                     state_r <= SS_DONE;
                  end
                  else
                  begin
                     addr_r <= addr_r + 1'b1;
                  end
               end
            end
            SS_DONE:
            begin
               // stays here until reset.
               state_r <= SS_DONE;
            end
            default:
            begin
               state_r <= SS_SEND;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

//--- design/link_endpoint.sv
`default_nettype none

module link_endpoint import stream_pkg::*;
(
   input  wire logic             clk_i,
   input  wire logic             rst_n_i,

   input  wire logic [X_W-1:0]   my_x_i,
   input  wire logic [Y_W-1:0]   my_y_i,

   // words from the streamer.
   input  wire logic             out_v_i,
   input  wire logic [ROM_W-1:0] out_word_i,
   output logic                  out_ready_o,

   // outgoing network link.
   output logic                  link_v_o,
   output logic      [PKT_W-1:0] link_pkt_o,
   input  wire logic             link_credit_i,

   // incoming network link.
   input  wire logic             in_v_i,
   input  wire logic [PKT_W-1:0] in_pkt_i,
   output logic                  in_credit_o,

   output logic                  freeze_o
);

   localparam logic [CREDIT_W-1:0] CREDIT_INIT = CREDIT_W'(MAX_CREDITS);

   logic [CREDIT_W-1:0] credit_r;
   logic                accept;

   logic                link_v_r;
   logic [PKT_W-1:0]    link_pkt_r;

   op_e                 in_op;
   logic [ADDR_W-1:0]   in_addr;
   logic [DATA_W-1:0]   in_data;
   logic                freeze_wr;

   logic                in_credit_r;
   logic                freeze_r;

   // a word may only be taken while a credit is held for it.
   assign out_ready_o = (credit_r != '0);
   assign accept      = out_v_i && out_ready_o;

   always_ff @(posedge clk_i)
   begin
      if (!rst_n_i)
      begin
         credit_r <= CREDIT_INIT;
      end
      else
      begin
         case ({accept, link_credit_i})
            2'b10:   credit_r <= credit_r - 1'b1;
            2'b01:   credit_r <= credit_r + 1'b1;
            default: credit_r <= credit_r;
         endcase
      end
   end

   // injection stage.
   always_ff @(posedge clk_i)
   begin
      if (!rst_n_i)
      begin
         link_v_r <= 1'b0;
      end
      else
      begin
         link_v_r <= accept;
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (accept)
      begin
         link_pkt_r <= {out_word_i, my_x_i, my_y_i};
      end
   end

   assign link_v_o   = link_v_r;
   assign link_pkt_o = link_pkt_r;

   // incoming packets are never stalled. Only a store to the freeze address matters.
   assign in_op     = op_e'(in_pkt_i[PKT_OP_LSB +: OP_W]);
   assign in_addr   = in_pkt_i[PKT_ADDR_LSB +: ADDR_W];
   assign in_data   = in_pkt_i[PKT_DATA_LSB +: DATA_W];
   assign freeze_wr = in_v_i && (in_op == OP_STORE) && (in_addr == FREEZE_ADDR);

   always_ff @(posedge clk_i)
   begin
      if (!rst_n_i)
      begin
         in_credit_r <= 1'b0;
         freeze_r    <= FREEZE_INIT;
      end
      else
      begin
         in_credit_r <= in_v_i;
         if (freeze_wr)
         begin
            freeze_r <= in_data[0];
         end
      end
   end

   assign in_credit_o = in_credit_r;
   assign freeze_o    = freeze_r;

endmodule

`default_nettype wire

//--- design/streamer_top.sv
`default_nettype none

module streamer_top import stream_pkg::*;
(
   input  wire logic             clk_i,
   input  wire logic             rst_n_i,

   input  wire logic [X_W-1:0]   my_x_i,
   input  wire logic [Y_W-1:0]   my_y_i,

   output logic                  link_v_o,
   output logic      [PKT_W-1:0] link_pkt_o,
   input  wire logic             link_credit_i,

   input  wire logic             in_v_i,
   input  wire logic [PKT_W-1:0] in_pkt_i,
   output logic                  in_credit_o,

   output logic                  done_o
);

   logic [ROM_ADDR_W-1:0] rom_addr;
   logic [ROM_W-1:0]      rom_data;
   logic                  out_v;
   logic [ROM_W-1:0]      out_word;
   logic                  out_ready;
   logic                  freeze;

   packet_rom packet_rom_inst (
      .rom_addr_i (rom_addr),
      .rom_data_o (rom_data)
   );

   packet_streamer packet_streamer_inst (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .freeze_i    (freeze),
      .rom_addr_o  (rom_addr),
      .rom_data_i  (rom_data),
      .out_v_o     (out_v),
      .out_word_o  (out_word),
      .out_ready_i (out_ready),
      .done_o      (done_o)
   );

   link_endpoint link_endpoint_inst (
      .clk_i         (clk_i),
      .rst_n_i       (rst_n_i),
      .my_x_i        (my_x_i),
      .my_y_i        (my_y_i),
      .out_v_i       (out_v),
      .out_word_i    (out_word),
      .out_ready_o   (out_ready),
      .link_v_o      (link_v_o),
      .link_pkt_o    (link_pkt_o),
      .link_credit_i (link_credit_i),
      .in_v_i        (in_v_i),
      .in_pkt_i      (in_pkt_i),
      .in_credit_o   (in_credit_o),
      .freeze_o      (freeze)
   );

endmodule

`default_nettype wire

//--- sim/streamer_properties.sv
`default_nettype none

module streamer_properties import stream_pkg::*;
(
   input  wire logic                clk_i,
   input  wire logic                rst_n_i,
   input  wire logic [CREDIT_W-1:0] credit_i,
   input  wire logic                out_v_i,
   input  wire logic                link_v_i,
   input  wire logic                in_v_i,
   input  wire logic                in_credit_i
);

   // goes high once any assertion below has failed.
   logic fail_seen = 1'b0;

   credit_bound: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      credit_i <= CREDIT_W'(MAX_CREDITS))
   else
   begin
      fail_seen = 1'b1;
      $error("credit count is above the limit");
   end

   // a packet on the link needs a valid word and a held credit in the cycle before.
   link_after_accept: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      link_v_i |-> $past(out_v_i) && ($past(credit_i) != '0))
   else
   begin
      fail_seen = 1'b1;
      $error("link_v_o without an accept that held a credit");
   end

   in_credit_delay: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      in_credit_i == $past(in_v_i))
   else
   begin
      fail_seen = 1'b1;
      $error("in_credit_o does not follow in_v_i by one cycle");
   end

   link_quiet_in_reset: assert property (@(posedge clk_i)
      !rst_n_i |=> !link_v_i)
   else
   begin
      fail_seen = 1'b1;
      $error("link_v_o is high during reset");
   end

endmodule

bind link_endpoint streamer_properties streamer_properties_inst (
   .clk_i       (clk_i),
   .rst_n_i     (rst_n_i),
   .credit_i    (credit_r),
   .out_v_i     (out_v_i),
   .link_v_i    (link_v_o),
   .in_v_i      (in_v_i),
   .in_credit_i (in_credit_o)
);

`default_nettype wire

//--- sim/streamer_tb.sv
`default_nettype none

module streamer_tb import stream_pkg::*;
();

   localparam int             CLK_HALF     = 20;
   localparam int             RESET_CYCLES = 8;
   localparam logic [X_W-1:0] NODE_X       = 2'd1;
   localparam logic [Y_W-1:0] NODE_Y       = 2'd2;
   localparam logic [X_W-1:0] REMOTE_X     = 2'd0;
   localparam logic [Y_W-1:0] REMOTE_Y     = 2'd3;

   logic             clk;
   logic             rst_n;
   logic [X_W-1:0]   my_x;
   logic [Y_W-1:0]   my_y;
   logic             link_v;
   logic [PKT_W-1:0] link_pkt;
   logic             link_credit;
   logic             in_v;
   logic [PKT_W-1:0] in_pkt;
   logic             in_credit;
   logic             done;
   logic             prop_fail;

   logic [ROM_W-1:0] rom_copy [ROM_WORDS];
   logic [PKT_W-1:0] pkt_q [$];
   int               due_q [$];
   logic [PKT_W-1:0] got_pkt;
   int               cycle_no     = 0;
   int               pkts_seen    = 0;
   int               pkts_checked = 0;
   int               credits_back = 0;
   int               snap;
   logic             hold_credits = 1'b0;
   logic             in_v_prev    = 1'b0;

   streamer_top streamer_top_inst (
      .clk_i         (clk),
      .rst_n_i       (rst_n),
      .my_x_i        (my_x),
      .my_y_i        (my_y),
      .link_v_o      (link_v),
      .link_pkt_o    (link_pkt),
      .link_credit_i (link_credit),
      .in_v_i        (in_v),
      .in_pkt_i      (in_pkt),
      .in_credit_o   (in_credit),
      .done_o        (done)
   );

   assign prop_fail = streamer_top_inst.link_endpoint_inst.streamer_properties_inst.fail_seen;

   initial
   begin
      clk = 1'b0;
      forever #CLK_HALF clk = ~clk;
   end

   function automatic logic [PKT_W-1:0] expected_pkt(input int index);
      return {rom_copy[index], NODE_X, NODE_Y};
   endfunction

   task automatic stop_run();
      $display("ERRORS FOUND");
      $fatal(1);
   endtask

   task automatic report_error(input string msg);
      $display("%s", msg);
      stop_run();
   endtask

   task automatic check_pkt(input string name, input logic [PKT_W-1:0] got,
                            input logic [PKT_W-1:0] exp);
      if (got !== exp)
      begin
         $display("[FAIL] %s got %h expected %h", name, got, exp);
         stop_run();
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp)
      begin
         $display("[FAIL] %s got %h expected %h", name, got, exp);
         stop_run();
      end
   endtask

   task automatic check_count(input string name, input logic [CREDIT_W-1:0] got,
                              input logic [CREDIT_W-1:0] exp);
      if (got !== exp)
      begin
         $display("[FAIL] %s got %h expected %h", name, got, exp);
         stop_run();
      end
   endtask

   // one incoming packet from the remote side, addressed to this node.
   task automatic send_in(input op_e op, input logic [ADDR_W-1:0] addr,
                          input logic [DATA_W-1:0] data);
      @(posedge clk);
      in_v   <= 1'b1;
      in_pkt <= {op, {MASK_W{1'b1}}, addr, data, NODE_X, NODE_Y, REMOTE_X, REMOTE_Y};
      @(posedge clk);
      in_v   <= 1'b0;
   endtask

   task automatic wait_sent(input int target, input int limit, input string what);
      int waited;
      waited = 0;
      @(negedge clk);
      while (pkts_seen < target)
      begin
         if (waited >= limit)
         begin
            report_error($sformatf("timeout while waiting for %s", what));
         end
         @(negedge clk);
         waited++;
      end
   endtask

   task automatic wait_checked(input int target, input int limit, input string what);
      int waited;
      waited = 0;
      @(negedge clk);
      while (pkts_checked < target)
      begin
         if (waited >= limit)
         begin
            report_error($sformatf("timeout while waiting for %s", what));
         end
         @(negedge clk);
         waited++;
      end
   endtask

   task automatic expect_quiet(input int cycles, input logic done_exp);
      repeat (cycles)
      begin
         @(negedge clk);
         check_bit("link_v_o", link_v, 1'b0);
         check_bit("done_o", done, done_exp);
      end
   endtask

   // the remote network takes every packet and pays its credit back later.
   always @(posedge clk)
   begin
      if (rst_n)
      begin
         cycle_no = cycle_no + 1;
         if (link_credit)
         begin
            credits_back = credits_back + 1;
         end
         if (link_v)
         begin
            check_bit("done_o", done, (pkts_seen == ROM_WORDS - 1));
            pkt_q.push_back(link_pkt);
            due_q.push_back(cycle_no + int'($urandom_range(0, 5)));
            pkts_seen = pkts_seen + 1;
            if (pkts_seen - credits_back > MAX_CREDITS)
            begin
               report_error("more packets are outstanding than the link has credits");
            end
         end
         if (!hold_credits && (due_q.size() > 0) && (due_q[0] <= cycle_no))
         begin
            void'(due_q.pop_front());
            link_credit <= 1'b1;
         end
         else
         begin
            link_credit <= 1'b0;
         end
      end
   end

   // each incoming packet must be paid back one cycle later.
   always @(posedge clk)
   begin
      if (rst_n)
      begin
         check_bit("in_credit_o", in_credit, in_v_prev);
         in_v_prev = in_v;
      end
   end

   always @(negedge clk)
   begin
      while (pkt_q.size() > 0)
      begin
         if (pkts_checked >= ROM_WORDS)
         begin
            report_error("a packet arrived after the whole table was sent");
         end
         got_pkt = pkt_q.pop_front();
         check_pkt("link_pkt_o", got_pkt, expected_pkt(pkts_checked));
         pkts_checked = pkts_checked + 1;
      end
      if (prop_fail)
      begin
         report_error("an assertion on the link endpoint failed");
      end
   end

   initial
   begin
      void'($urandom(32'h3b6a));
      $readmemh(ROM_FILE, rom_copy);
      rst_n       = 1'b0;
      my_x        = NODE_X;
      my_y        = NODE_Y;
      link_credit = 1'b0;
      in_v        = 1'b0;
      in_pkt      = '0;
      repeat (RESET_CYCLES) @(posedge clk);
      rst_n <= 1'b1;

      // the node stays frozen, and a load or a store elsewhere does not wake it.
      send_in(OP_LOAD, FREEZE_ADDR, 32'h0);
      send_in(OP_STORE, FREEZE_ADDR + 12'h004, 32'h0);
      expect_quiet(30, 1'b0);

      // with credits held back only MAX_CREDITS packets may leave.
      hold_credits = 1'b1;
      send_in(OP_STORE, FREEZE_ADDR, 32'h0);
      wait_sent(1, 40, "the first packet after the unfreeze store");
      // the burst goes out in back-to-back cycles, well inside this window.
      repeat (2 * MAX_CREDITS) @(negedge clk);
      check_count("outstanding credits", CREDIT_W'(pkts_seen - credits_back),
                  CREDIT_W'(MAX_CREDITS));
      expect_quiet(20, 1'b0);
      hold_credits = 1'b0;

      send_in(OP_LOAD, 12'h010, 32'h0);
      send_in(OP_NOP, 12'h000, 32'h0);
      send_in(OP_STORE, 12'h020, 32'h1);

      wait_sent(8, 200, "eight packets before the re-freeze");
      send_in(OP_STORE, FREEZE_ADDR, 32'h1);
      @(negedge clk);
      snap = pkts_seen;
      repeat (2) @(negedge clk);
      expect_quiet(20, 1'b0);
      if (pkts_seen > snap + 1)
      begin
         report_error("packets kept going out after the re-freeze store");
      end

      send_in(OP_STORE, FREEZE_ADDR, 32'h0);
      wait_checked(ROM_WORDS, 400, "every table packet to be compared");
      expect_quiet(50, 1'b1);

      if (prop_fail)
      begin
         report_error("an assertion on the link endpoint failed");
      end
      else
      begin
         $display("NO ERRORS");
         $finish;
      end
   end

endmodule

`default_nettype wire

//--- design/packet_rom.hex
// op mask addr data dest, 14 hex digits per word
// top digit holds op, bottom digit holds dest x and dest y
2f100000000015
2f104cafe00016
1f20812345678a
2310c0000abcdf
2c110deadbeef0
1f214000000003
2f11800c0ffee5
0000000000000c
2111c5a5a5a5a7
1f220000000001
2f12476543210b
28128a5a5a5a5e
1f22c000000102
2f1301234abcd9
24134ffffffff4
2f1380badf00d8

//--- compile.f
design/stream_pkg.sv
design/packet_rom.sv
design/packet_streamer.sv
design/link_endpoint.sv
design/streamer_top.sv
sim/streamer_properties.sv
sim/streamer_tb.sv

//--- Makefile
# Verilator build and run for the boot-time packet streamer.

VERILATOR ?= verilator
TOP       ?= streamer_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= NO ERRORS

SOURCES := $(wildcard design/*.sv sim/*.sv) design/packet_rom.hex

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
